// File: src.f
rtl/bridge_pkg.sv
rtl/uart_rx.sv
rtl/cmd_decode.sv
rtl/spi_master.sv
rtl/result_queue.sv
rtl/uart_tx.sv
rtl/spi_uart_bridge.sv
sim/tb_spi_uart_bridge.sv

// File: Makefile
# Verilator build and run of the UART to SPI bridge testbench

TOP = tb_spi_uart_bridge
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/tb_spi_uart_bridge.sv
// Testbench for the UART to SPI command bridge
// Host UART model, SPI slave model with random replies, reference queues

`timescale 1ns/100ps
`default_nettype none

module tb_spi_uart_bridge import bridge_pkg::*; ();

  logic sys_clk;
  logic reset_all_cmd_w;
  logic i_uart_rx;
  logic i_spi_miso;
  wire  o_uart_tx;
  wire  o_spi_cs_n;
  wire  o_spi_sclk;
  wire  o_spi_mosi;
  wire  o_slm_reset_n;

  // Reference model state
  logic [15:0] exp_frames[$];
  logic [7:0]  exp_replies[$];
  int          errors = 0;
  int          frames_sent = 0;
  int          frames_seen = 0;
  int          bytes_seen = 0;
  int          pulses_exp = 0;
  int          pulses_seen = 0;
  string       test_name = "init";

  spi_uart_bridge UUT (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .i_uart_rx       (i_uart_rx),
    .i_spi_miso      (i_spi_miso),
    .o_uart_tx       (o_uart_tx),
    .o_spi_cs_n      (o_spi_cs_n),
    .o_spi_sclk      (o_spi_sclk),
    .o_spi_mosi      (o_spi_mosi),
    .o_slm_reset_n   (o_slm_reset_n)
  );

  initial begin
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;
  end

  task automatic count_mismatch(input string what, input int expected, input int actual);
    errors++;
    $display("Mismatch %s %s: expected %0h actual %0h", test_name, what, expected, actual);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("ERROR %s: %s", test_name, msg);
  endtask

  ////////////////////////////////////////
  // Host side
  ////////////////////////////////////////
  // 8N1 LSB first with edges 1 ns after sys_clk
  task automatic send_byte(input logic [7:0] value);
    int i;
    @(posedge sys_clk);
    #1 i_uart_rx = 1'b0;
    repeat (UART_CLKS_PER_BIT) @(posedge sys_clk);
    for (i = 0; i < 8; i++) begin
      #1 i_uart_rx = value[i];
      repeat (UART_CLKS_PER_BIT) @(posedge sys_clk);
    end
    #1 i_uart_rx = 1'b1;
    repeat (UART_CLKS_PER_BIT) @(posedge sys_clk);
  endtask

  // Model updated first as the frame starts inside the stop bit
  task automatic run_cmd(input logic [7:0] value);
    case (value)
      CMD_WHOAMI: begin
        exp_frames.push_back(16'hF800);
        frames_sent++;
      end
      CMD_SET_CLK: begin
        exp_frames.push_back(16'h0932);
        frames_sent++;
      end
      CMD_GET_CLK: begin
        exp_frames.push_back(16'h8900);
        frames_sent++;
      end
      CMD_RESET: pulses_exp++;
      default: ;
    endcase
    send_byte(value);
  endtask

  // Until all frames, replies and reset pulses are accounted for
  task automatic wait_settled(input int limit);
    int n;
    n = 0;
    while ((exp_frames.size() != 0 || exp_replies.size() != 0 ||
            pulses_seen != pulses_exp) && n < limit) begin
      @(posedge sys_clk);
      n++;
    end
    assert (n < limit) else report_failure("timeout waiting for frames, replies and pulses");
  endtask

  ////////////////////////////////////////
  // SPI slave model
  ////////////////////////////////////////
  initial begin : spi_slave
    logic        cs_q;
    logic        sck_q;
    logic        drive;
    logic        miso_val;
    int          bit_idx;
    int          rises;
    logic [15:0] frame;
    logic [7:0]  reply;
    i_spi_miso = 1'b0;
    cs_q = 1'b1;
    sck_q = 1'b0;
    bit_idx = 0;
    rises = 0;
    frame = '0;
    reply = '0;
    forever begin
      @(negedge sys_clk);
      drive = 1'b0;
      miso_val = 1'b0;
      if (!reset_all_cmd_w) begin
        if (cs_q && !o_spi_cs_n) begin
          // New frame with a fresh reply byte
          bit_idx = 0;
          rises = 0;
          frame = '0;
          reply = 8'($urandom);
          exp_replies.push_back(reply);
          drive = 1'b1;
        end else if (!o_spi_cs_n && sck_q && !o_spi_sclk) begin
          bit_idx++;
          drive = 1'b1;
        end
        // Reply only in the lower byte MSB first
        if (drive && bit_idx >= 8) miso_val = reply[15 - bit_idx];
        if (!o_spi_cs_n && !sck_q && o_spi_sclk) begin
          frame = {frame[14:0], o_spi_mosi};
          rises++;
        end
        if (!cs_q && o_spi_cs_n) begin
          frames_seen++;
          assert (rises == SPI_FRAME_BITS) else count_mismatch("sck count", SPI_FRAME_BITS, rises);
          if (exp_frames.size() == 0) begin
            report_failure($sformatf("unexpected SPI frame %h", frame));
          end else begin
            assert (frame == exp_frames[0]) else count_mismatch("frame", exp_frames[0], frame);
            void'(exp_frames.pop_front());
          end
        end
      end
      cs_q = o_spi_cs_n;
      sck_q = o_spi_sclk;
      if (drive) begin
        @(posedge sys_clk);
        #1 i_spi_miso = miso_val;
      end
    end
  end

  ////////////////////////////////////////
  // UART monitor and reset pulse monitor
  ////////////////////////////////////////
  initial begin : uart_monitor
    logic [7:0] data;
    int         i;
    data = '0;
    forever begin
      @(negedge sys_clk);
      if (!reset_all_cmd_w && o_uart_tx == 1'b0) begin
        // Centre of the start bit and then one bit time per sample
        repeat (UART_CLKS_PER_BIT / 2) @(negedge sys_clk);
        assert (o_uart_tx == 1'b0) else report_failure("UART start bit too short");
        for (i = 0; i < 8; i++) begin
          repeat (UART_CLKS_PER_BIT) @(negedge sys_clk);
          data[i] = o_uart_tx;
        end
        repeat (UART_CLKS_PER_BIT) @(negedge sys_clk);
        assert (o_uart_tx == 1'b1) else report_failure("UART stop bit low");
        bytes_seen++;
        if (exp_replies.size() == 0) begin
          report_failure($sformatf("unexpected UART byte %h", data));
        end else begin
          assert (data == exp_replies[0]) else count_mismatch("reply", exp_replies[0], data);
          void'(exp_replies.pop_front());
        end
      end
    end
  end

  // Low time counted while the reset input is released
  initial begin : reset_pulse_monitor
    int low_run;
    low_run = 0;
    forever begin
      @(negedge sys_clk);
      if (reset_all_cmd_w) begin
        low_run = 0;
      end else if (!o_slm_reset_n) begin
        low_run++;
      end else if (low_run != 0) begin
        pulses_seen++;
        assert (low_run == int'(RESET_PULSE_CYCLES))
          else count_mismatch("slm reset length", int'(RESET_PULSE_CYCLES), low_run);
        low_run = 0;
      end
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin : main_seq
    int          pick;
    logic [7:0]  value;
    reset_all_cmd_w = 1'b1;
    i_uart_rx = 1'b1;
    void'($urandom(18));
    test_name = "reset";
    repeat (3) @(posedge sys_clk);
    #1 reset_all_cmd_w = 1'b0;
    pulses_exp = 1;
    @(negedge sys_clk);
    assert (o_spi_cs_n === 1'b1) else count_mismatch("cs_n", 1, int'(o_spi_cs_n));
    assert (o_uart_tx === 1'b1) else count_mismatch("uart_tx", 1, int'(o_uart_tx));
    wait_settled(200);

    test_name = "directed";
    run_cmd(CMD_WHOAMI);
    run_cmd(CMD_SET_CLK);
    run_cmd(CMD_GET_CLK);
    run_cmd(CMD_RESET);
    wait_settled(20000);

    // Half command bytes and half arbitrary values
    test_name = "random";
    repeat (40) begin
      pick = $urandom % 8;
      case (pick)
        0: value = CMD_WHOAMI;
        1: value = CMD_SET_CLK;
        2: value = CMD_GET_CLK;
        3: value = CMD_RESET;
        default: value = 8'($urandom);
      endcase
      run_cmd(value);
    end
    wait_settled(40000);
    // Quiet period to catch stray frames or bytes
    repeat (2 * UART_FRAME_BITS * UART_CLKS_PER_BIT) @(posedge sys_clk);

    test_name = "totals";
    assert (frames_seen == frames_sent) else count_mismatch("frame count", frames_sent, frames_seen);
    assert (bytes_seen == frames_sent) else count_mismatch("reply count", frames_sent, bytes_seen);
    assert (pulses_seen == pulses_exp) else count_mismatch("pulse count", pulses_exp, pulses_seen);
    $display("Errors: %0d, frames %0d, replies %0d, reset pulses %0d",
             errors, frames_seen, bytes_seen, pulses_seen);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/spi_uart_bridge.sv
// Top of the UART to SPI command bridge for the SLM board
// Host bytes in, SPI register frames out, reply bytes back to the host

`timescale 1ns/100ps
`default_nettype none

module spi_uart_bridge import bridge_pkg::*; (
  input  wire sys_clk,
  input  wire reset_all_cmd_w,
  input  wire i_uart_rx,
  input  wire i_spi_miso,
  output wire o_uart_tx,
  output wire o_spi_cs_n,
  output wire o_spi_sclk,
  output wire o_spi_mosi,
  output wire o_slm_reset_n
);

  // Receive to decode
  wire             rx_valid;
  wire [7:0]       rx_byte;
  // Decode to SPI
  wire             spi_req;
  wire spi_frame_u spi_frame;
  // SPI to queue
  wire             spi_ack;
  wire [7:0]       spi_rx_byte;
  // Queue to transmit
  wire             tx_req;
  wire [7:0]       tx_byte;
  wire             tx_ack;

  ////////////////////////////////////////
  // Host side receive and decode
  ////////////////////////////////////////
  uart_rx u_uart_rx (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .i_uart_rx       (i_uart_rx),
    .o_rx_valid      (rx_valid),
    .o_rx_byte       (rx_byte)
  );

  cmd_decode u_cmd_decode (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .i_rx_valid      (rx_valid),
    .i_rx_byte       (rx_byte),
    .i_spi_ack       (spi_ack),
    .o_spi_req       (spi_req),
    .o_spi_frame     (spi_frame),
    .o_slm_reset_n   (o_slm_reset_n)
  );

  ////////////////////////////////////////
  // SLM SPI and reply path
  ////////////////////////////////////////
  spi_master u_spi_master (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .i_spi_req       (spi_req),
    .i_spi_frame     (spi_frame),
    .i_spi_miso      (i_spi_miso),
    .o_spi_ack       (spi_ack),
    .o_spi_rx_byte   (spi_rx_byte),
    .o_spi_cs_n      (o_spi_cs_n),
    .o_spi_sclk      (o_spi_sclk),
    .o_spi_mosi      (o_spi_mosi)
  );

  result_queue u_result_queue (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .i_spi_ack       (spi_ack),
    .i_spi_rx_byte   (spi_rx_byte),
    .i_tx_ack        (tx_ack),
    .o_tx_req        (tx_req),
    .o_tx_byte       (tx_byte)
  );

  uart_tx u_uart_tx (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .i_tx_req        (tx_req),
    .i_tx_byte       (tx_byte),
    .o_tx_ack        (tx_ack),
    .o_uart_tx       (o_uart_tx)
  );

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
// UART transmitter for reply bytes
// 8N1 at UART_CLKS_PER_BIT, ack raised after the stop bit

`timescale 1ns/100ps
`default_nettype none

module uart_tx import bridge_pkg::*; (
  input  wire        sys_clk,
  input  wire        reset_all_cmd_w,
  input  wire        i_tx_req,
  input  wire  [7:0] i_tx_byte,
  output logic       o_tx_ack,
  output logic       o_uart_tx
);

  logic [1:0]            state;
  logic [UART_CNT_W-1:0] clk_cnt;
  logic [3:0]            bit_idx;
  // Data bits then stop bit, start bit goes straight to the line
  logic [8:0]            tx_shift;
  logic                  start;
  logic                  bit_tick;
  logic                  last_bit;

  assign start    = (state == TX_IDLE) && i_tx_req && !o_tx_ack;
  assign bit_tick = (state == TX_SEND) && (clk_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1));
  assign last_bit = (bit_idx == 4'(UART_FRAME_BITS - 1));

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state     <= TX_IDLE;
      clk_cnt   <= '0;
      bit_idx   <= '0;
      o_tx_ack  <= 1'b0;
      o_uart_tx <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          if (start) begin
            // Start bit
            o_uart_tx <= 1'b0;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            state     <= TX_SEND;
          end
        end
        TX_SEND: begin
          if (bit_tick) begin
            clk_cnt <= '0;
            if (last_bit) begin
              // Stop bit fully sent
              o_tx_ack <= 1'b1;
              state    <= TX_ACK;
            end else begin
              o_uart_tx <= tx_shift[0];
              bit_idx   <= bit_idx + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        TX_ACK: begin
          if (!i_tx_req) begin
            o_tx_ack <= 1'b0;
            state    <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // LSB first, stop bit shifted in behind the data
  always_ff @(posedge sys_clk) begin
    if (start) begin
      tx_shift <= {1'b1, i_tx_byte};
    end else if (bit_tick) begin
      tx_shift <= {1'b1, tx_shift[8:1]};
    end
  end

endmodule

`default_nettype wire

// File: rtl/result_queue.sv
// Result queue between the SPI and UART stages
// Stores reply bytes on each finished SPI transfer, drops them when full,
// and offers the oldest byte to the UART transmitter

`timescale 1ns/100ps
`default_nettype none

module result_queue import bridge_pkg::*; (
  input  wire        sys_clk,
  input  wire        reset_all_cmd_w,
  input  wire        i_spi_ack,
  input  wire  [7:0] i_spi_rx_byte,
  input  wire        i_tx_ack,
  output logic       o_tx_req,
  output logic [7:0] o_tx_byte
);

  logic [7:0]              mem [RESULT_DEPTH];
  logic [RESULT_PTR_W-1:0] wr_ptr;
  logic [RESULT_PTR_W-1:0] rd_ptr;
  logic [RESULT_PTR_W:0]   count;
  logic                    spi_ack_q;
  logic                    tx_ack_q;
  logic                    full;
  logic                    push;
  logic                    pop;

  assign full = (count == (RESULT_PTR_W + 1)'(RESULT_DEPTH));

  // Write on rising ack, reply dropped if no room
  assign push = i_spi_ack && !spi_ack_q && !full;
  // Entry done once the transmitter releases ack
  assign pop  = tx_ack_q && !i_tx_ack;

  ////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      spi_ack_q <= 1'b0;
      tx_ack_q  <= 1'b0;
    end else begin
      spi_ack_q <= i_spi_ack;
      tx_ack_q  <= i_tx_ack;
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (push) mem[wr_ptr] <= i_spi_rx_byte;
  end

  ////////////////////////////////////////
  // Transmit request, four phase
  ////////////////////////////////////////
  // Wait out the pop cycle so the next head is current
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      o_tx_req <= 1'b0;
    end else if (o_tx_req && i_tx_ack) begin
      o_tx_req <= 1'b0;
    end else if (!o_tx_req && !i_tx_ack && !tx_ack_q && count != '0) begin
      o_tx_req <= 1'b1;
    end
  end

  // Head of queue, held until the pop
  assign o_tx_byte = mem[rd_ptr];

  a_count_bound: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    count <= (RESULT_PTR_W + 1)'(RESULT_DEPTH));

endmodule

`default_nettype wire

// File: rtl/spi_master.sv
// SPI master, execute stage
// Shifts one 16 bit mode 0 frame MSB first and keeps the last 8 MISO bits
// as the reply byte, then acknowledges the request

`timescale 1ns/100ps
`default_nettype none

module spi_master import bridge_pkg::*; (
  input  wire             sys_clk,
  input  wire             reset_all_cmd_w,
  input  wire             i_spi_req,
  input  wire spi_frame_u i_spi_frame,
  input  wire             i_spi_miso,
  output logic            o_spi_ack,
  output logic      [7:0] o_spi_rx_byte,
  output logic            o_spi_cs_n,
  output logic            o_spi_sclk,
  output logic            o_spi_mosi
);

  logic [1:0]                state;
  logic [SPI_DIV_W-1:0]      div_cnt;
  logic [SPI_BIT_W-1:0]      bit_cnt;
  logic [SPI_FRAME_BITS-1:0] tx_shift;
  logic [7:0]                rx_shift;
  logic                      half_tick;
  logic                      sck_rise;
  logic                      sck_fall;
  logic                      last_bit;

  // Half period divider
  assign half_tick = (div_cnt == SPI_DIV_W'(SPI_HALF_PERIOD - 1));
  assign sck_rise  = (state == SPI_SHIFT) && half_tick && !o_spi_sclk;
  assign sck_fall  = (state == SPI_SHIFT) && half_tick && o_spi_sclk;
  assign last_bit  = (bit_cnt == SPI_BIT_W'(SPI_FRAME_BITS - 1));

  // MSB of the shifter sits on MOSI
  assign o_spi_mosi = tx_shift[SPI_FRAME_BITS-1];

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state      <= SPI_IDLE;
      div_cnt    <= '0;
      bit_cnt    <= '0;
      tx_shift   <= '0;
      o_spi_sclk <= 1'b0;
      o_spi_cs_n <= 1'b1;
      o_spi_ack  <= 1'b0;
    end else begin
      case (state)
        SPI_IDLE: begin
          if (i_spi_req && !o_spi_ack) begin
            // CS low, first bit set up half a period before SCK rises
            o_spi_cs_n <= 1'b0;
            tx_shift   <= {i_spi_frame.raw.addr, i_spi_frame.raw.data};
            div_cnt    <= '0;
            bit_cnt    <= '0;
            state      <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
          if (half_tick) o_spi_sclk <= !o_spi_sclk;
          // Next bit on falling SCK
          if (sck_fall) begin
            if (last_bit) begin
              o_spi_cs_n <= 1'b1;
              o_spi_ack  <= 1'b1;
              state      <= SPI_DONE;
            end else begin
              bit_cnt  <= bit_cnt + 1'b1;
              tx_shift <= {tx_shift[SPI_FRAME_BITS-2:0], 1'b0};
            end
          end
        end
        SPI_DONE: begin
          // Ack released once the request drops
          if (!i_spi_req) begin
            o_spi_ack <= 1'b0;
            state     <= SPI_IDLE;
          end
        end
        default: state <= SPI_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Reply capture
  ////////////////////////////////////////
  // MISO sampled on rising SCK, last 8 samples are the data byte
  always_ff @(posedge sys_clk) begin
    if (sck_rise) rx_shift <= {rx_shift[6:0], i_spi_miso};
  end

  always_ff @(posedge sys_clk) begin
    if (sck_fall && last_bit) o_spi_rx_byte <= rx_shift;
  end

  a_sclk_idle_low: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    o_spi_cs_n |-> !o_spi_sclk);

endmodule

`default_nettype wire

// File: rtl/cmd_decode.sv
// Command decode stage
// Maps host bytes to SPI register frames, requests the transfer,
// and times the active low SLM reset pulse

`timescale 1ns/100ps
`default_nettype none

module cmd_decode import bridge_pkg::*; (
  input  wire             sys_clk,
  input  wire             reset_all_cmd_w,
  input  wire             i_rx_valid,
  input  wire       [7:0] i_rx_byte,
  input  wire             i_spi_ack,
  output logic            o_spi_req,
  output spi_frame_u      o_spi_frame,
  output logic            o_slm_reset_n
);

  spi_frame_u next_frame;
  logic       is_spi_cmd;
  logic       accept;
  logic [3:0] pulse_cnt;

  // New bytes only while the SPI handshake is idle
  assign accept = i_rx_valid && !o_spi_req && !i_spi_ack;

  // Register view of the frame for each SPI command
  always_comb begin
    next_frame = '0;
    is_spi_cmd = 1'b0;
    case (i_rx_byte)
      CMD_WHOAMI: begin
        is_spi_cmd                = 1'b1;
        next_frame.acc.rd       = 1'b1;
        next_frame.acc.reg_addr = REG_WHOAMI;
      end
      CMD_SET_CLK: begin
        is_spi_cmd                = 1'b1;
        next_frame.acc.reg_addr = REG_CLK_FREQ;
        next_frame.acc.wdata    = CLK_FREQ_MHZ;
      end
      CMD_GET_CLK: begin
        is_spi_cmd                = 1'b1;
        next_frame.acc.rd       = 1'b1;
        next_frame.acc.reg_addr = REG_CLK_FREQ;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // SPI request, four phase
  ////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      o_spi_req <= 1'b0;
    end else if (accept && is_spi_cmd) begin
      o_spi_req <= 1'b1;
    end else if (o_spi_req && i_spi_ack) begin
      o_spi_req <= 1'b0;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (accept && is_spi_cmd) o_spi_frame <= next_frame;
  end

  ////////////////////////////////////////
  // SLM reset countdown
  ////////////////////////////////////////
  // Loaded by the reset input and by 'r'
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      pulse_cnt <= RESET_PULSE_CYCLES;
    end else if (accept && i_rx_byte == CMD_RESET) begin
      pulse_cnt <= RESET_PULSE_CYCLES;
    end else if (pulse_cnt != 4'd0) begin
      pulse_cnt <= pulse_cnt - 1'b1;
    end
  end

  // Low while counting
  assign o_slm_reset_n = (pulse_cnt == 4'd0);

  a_frame_stable: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    o_spi_req |=> (!o_spi_req || $stable(o_spi_frame)));

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
// UART receiver for host command bytes
// 8N1 at UART_CLKS_PER_BIT, each bit sampled at its centre

`timescale 1ns/100ps
`default_nettype none

module uart_rx import bridge_pkg::*; (
  input  wire        sys_clk,
  input  wire        reset_all_cmd_w,
  input  wire        i_uart_rx,
  output logic       o_rx_valid,
  output logic [7:0] o_rx_byte
);

  // Two flop synchronizer, line idles high
  logic                  rx_meta;
  logic                  rx_sync;
  logic [1:0]            state;
  logic [UART_CNT_W-1:0] clk_cnt;
  logic [2:0]            bit_idx;
  logic                  half_tick;
  logic                  bit_tick;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= i_uart_rx;
      rx_sync <= rx_meta;
    end
  end

  // Middle of start bit, then one full bit per sample
  assign half_tick = (clk_cnt == UART_CNT_W'((UART_CLKS_PER_BIT / 2) - 1));
  assign bit_tick  = (clk_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1));

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state      <= RX_IDLE;
      clk_cnt    <= '0;
      bit_idx    <= '0;
      o_rx_valid <= 1'b0;
    end else begin
      o_rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          // Falling edge on the line
          if (!rx_sync) state <= RX_START;
        end
        RX_START: begin
          if (half_tick) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            // Glitch shorter than half a bit goes back to idle
            state   <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_tick) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= RX_STOP;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_tick) begin
            // Framing error drops the byte
            o_rx_valid <= rx_sync;
            state      <= RX_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Data shift, LSB first
  always_ff @(posedge sys_clk) begin
    if (state == RX_DATA && bit_tick) o_rx_byte <= {rx_sync, o_rx_byte[7:1]};
  end

  a_rx_valid_pulse: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    o_rx_valid |=> !o_rx_valid);

endmodule

`default_nettype wire

// File: rtl/bridge_pkg.sv
// Shared constants and frame type for the UART to SPI command bridge
// Timing at 50 MHz, host command bytes, SLM register map, FSM codes

`default_nettype none

package bridge_pkg;

  ////////////////////////////////////////
  // Timing
  ////////////////////////////////////////
  // 50 MHz over 115200 baud
  localparam int UART_CLKS_PER_BIT = 434;
  localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);
  // Start bit, 8 data bits, stop bit
  localparam int UART_FRAME_BITS   = 10;
  // SCK runs at 6.25 MHz
  localparam int SPI_HALF_PERIOD   = 4;
  localparam int SPI_DIV_W         = $clog2(SPI_HALF_PERIOD);
  localparam int SPI_FRAME_BITS    = 16;
  localparam int SPI_BIT_W         = $clog2(SPI_FRAME_BITS);
  // 200 ns low, well above the SLM minimum
  localparam logic [3:0] RESET_PULSE_CYCLES = 4'd10;
  localparam int RESULT_DEPTH      = 4;
  localparam int RESULT_PTR_W      = $clog2(RESULT_DEPTH);

  ////////////////////////////////////////
  // Host commands and SLM registers
  ////////////////////////////////////////
  localparam logic [7:0] CMD_RESET    = 8'h72;  // 'r'
  localparam logic [7:0] CMD_WHOAMI   = 8'h64;  // 'd'
  localparam logic [7:0] CMD_SET_CLK  = 8'h73;  // 's'
  localparam logic [7:0] CMD_GET_CLK  = 8'h61;  // 'a'
  localparam logic [6:0] REG_WHOAMI   = 7'h78;
  localparam logic [6:0] REG_CLK_FREQ = 7'h09;
  // Clock frequency in MHz
  localparam logic [7:0] CLK_FREQ_MHZ = 8'h32;

  // FSM state codes
  localparam logic [1:0] RX_IDLE   = 2'd0;
  localparam logic [1:0] RX_START  = 2'd1;
  localparam logic [1:0] RX_DATA   = 2'd2;
  localparam logic [1:0] RX_STOP   = 2'd3;
  localparam logic [1:0] SPI_IDLE  = 2'd0;
  localparam logic [1:0] SPI_SHIFT = 2'd1;
  localparam logic [1:0] SPI_DONE  = 2'd2;
  localparam logic [1:0] TX_IDLE   = 2'd0;
  localparam logic [1:0] TX_SEND   = 2'd1;
  localparam logic [1:0] TX_ACK    = 2'd2;

  // One SPI frame, seen as raw bytes or as a register access
  typedef union packed {
    struct packed {
      logic [7:0] addr;
      logic [7:0] data;
    } raw;
    struct packed {
      logic       rd;
      logic [6:0] reg_addr;
      logic [7:0] wdata;
    } acc;
  } spi_frame_u;

endpackage

`default_nettype wire
